/* design/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Frame and channel geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int FRAME_HEIGHT     = 8;
    localparam int FRAME_WIDTH      = 8;
    localparam int PIXELS_PER_FRAME = FRAME_HEIGHT * FRAME_WIDTH;
    localparam int IN_CHANNELS      = 2;
    localparam int OUT_CHANNELS     = 2;
    localparam int KERNEL_SIZE      = 3;

    // Datapath widths
    localparam int ACT_WIDTH         = 8;
    localparam int WEIGHT_WIDTH      = 8;
    // 18 products of 9-bit by 8-bit signed values fit in 21 bits
    localparam int ACC_WIDTH         = 21;
    localparam int WEIGHT_COUNT      = OUT_CHANNELS * IN_CHANNELS * KERNEL_SIZE * KERNEL_SIZE;
    localparam int WEIGHT_ADDR_WIDTH = 6;

    ////////////////////////////////////////////////////////////////////////////
    // Stream payloads and internal buses
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [IN_CHANNELS-1:0][ACT_WIDTH-1:0] chan;
    } in_pixel_t;

    typedef struct packed {
        logic [OUT_CHANNELS-1:0][ACT_WIDTH-1:0] chan;
    } out_pixel_t;

    // Zero-padded neighbourhood, indexed [channel][kernel row][kernel column]
    typedef logic [IN_CHANNELS-1:0][KERNEL_SIZE-1:0][KERNEL_SIZE-1:0][ACT_WIDTH-1:0] window_t;

    // Index order is output channel, input channel, kernel row, kernel column
    typedef logic [WEIGHT_COUNT-1:0][WEIGHT_WIDTH-1:0] weight_set_t;

    typedef struct packed {
        in_pixel_t pixel;
        logic      last;
    } in_beat_t;

    typedef struct packed {
        out_pixel_t pixel;
        logic       last;
    } out_beat_t;

    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } coord_t;

endpackage : conv_pkg

`default_nettype wire

/* design/frame_store.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_store
    import conv_pkg::*;
(
    input  wire logic     clock_i,
    input  wire logic     reset_i,

    // Input pixel stream
    input  wire logic     s_valid_i,
    output logic          s_ready_o,
    input  wire in_beat_t s_beat_i,

    // Window read side, owned by the engine
    input  wire coord_t   read_coord_i,
    input  wire logic     frame_done_i,
    output logic          frame_full_o,
    output window_t       window_o,

    output logic          frame_error_o
);

    // Whole frame held in raster order
    in_pixel_t  pixels [PIXELS_PER_FRAME];
    logic [5:0] beat_count;
    logic       accept;
    logic       final_beat;

    // Ready only while the store is being filled
    assign s_ready_o  = !frame_full_o;
    assign accept     = s_valid_i && s_ready_o;
    assign final_beat = (beat_count == 6'(PIXELS_PER_FRAME - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock_i) begin
        if (accept) begin
            pixels[beat_count] <= s_beat_i.pixel;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            beat_count    <= '0;
            frame_full_o  <= 1'b0;
            frame_error_o <= 1'b0;
        end else begin
            if (accept) begin
                if (final_beat) begin
                    beat_count   <= '0;
                    frame_full_o <= 1'b1;
                end else begin
                    beat_count <= beat_count + 6'd1;
                end
                // tlast must mark exactly the 64th beat, flag sticks until reset
                if (s_beat_i.last != final_beat) begin
                    frame_error_o <= 1'b1;
                end
            end else if (frame_done_i) begin
                // Engine has streamed the whole frame out
                frame_full_o <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side, padded 3x3 window around the read coordinate
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        int r;
        int c;
        window_o = '0;
        for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
            for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                r = int'(read_coord_i.row) + kr - KERNEL_SIZE / 2;
                c = int'(read_coord_i.col) + kc - KERNEL_SIZE / 2;
                // Neighbours off the frame stay zero
                if (r >= 0 && r < FRAME_HEIGHT && c >= 0 && c < FRAME_WIDTH) begin
                    for (int ic = 0; ic < IN_CHANNELS; ic++) begin
                        window_o[ic][kr][kc] = pixels[r * FRAME_WIDTH + c].chan[ic];
                    end
                end
            end
        end
    end

endmodule : frame_store

`default_nettype wire

/* design/weight_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module weight_bank
    import conv_pkg::*;
(
    input  wire logic                           clock_i,
    input  wire logic                           reset_i,

    // Addressed write port, one weight per strobe
    input  wire logic                           weight_we_i,
    input  wire logic [WEIGHT_ADDR_WIDTH-1:0]   weight_addr_i,
    input  wire logic signed [WEIGHT_WIDTH-1:0] weight_data_i,

    // All kernel weights at once
    output weight_set_t                         weights_o
);

    logic signed [WEIGHT_WIDTH-1:0] weight_regs [WEIGHT_COUNT];

    ////////////////////////////////////////////////////////////////////////////
    // Address decode, one enable per register
    ////////////////////////////////////////////////////////////////////////////

    // Addresses past the last weight match no register and are dropped
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            for (int i = 0; i < WEIGHT_COUNT; i++) begin
                weight_regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < WEIGHT_COUNT; i++) begin
                if (weight_we_i && weight_addr_i == WEIGHT_ADDR_WIDTH'(i)) begin
                    weight_regs[i] <= weight_data_i;
                end
            end
        end
    end

    // Flatten into the index-ordered bus
    always_comb begin
        for (int i = 0; i < WEIGHT_COUNT; i++) begin
            weights_o[i] = weight_regs[i];
        end
    end

endmodule : weight_bank

`default_nettype wire

/* design/conv_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_engine
    import conv_pkg::*;
(
    input  wire logic        clock_i,
    input  wire logic        reset_i,

    // Frame store handshake
    input  wire logic        frame_full_i,
    input  wire window_t     window_i,
    output coord_t           read_coord_o,
    output logic             frame_done_o,

    input  wire weight_set_t weights_i,

    // Output pixel stream
    output logic             m_valid_o,
    input  wire logic        m_ready_i,
    output out_beat_t        m_beat_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STREAM,
        ST_DONE
    } state_t;

    state_t    state;
    coord_t    next_coord;
    out_beat_t next_beat;
    logic      load_beat;

    ////////////////////////////////////////////////////////////////////////////
    // Multiply-accumulate and clamp
    ////////////////////////////////////////////////////////////////////////////

    // Signed sum of the 18 products feeding one output channel
    function automatic logic signed [ACC_WIDTH-1:0] channel_sum(
        input window_t     win,
        input weight_set_t wts,
        input int          oc
    );
        logic signed [ACC_WIDTH-1:0]    acc;
        logic signed [ACT_WIDTH:0]      act;
        logic signed [WEIGHT_WIDTH-1:0] wt;
        int                             idx;
        acc = '0;
        for (int ic = 0; ic < IN_CHANNELS; ic++) begin
            for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
                for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                    idx = ((oc * IN_CHANNELS + ic) * KERNEL_SIZE + kr) * KERNEL_SIZE + kc;
                    // Unsigned activation widened with a zero sign bit
                    act = $signed({1'b0, win[ic][kr][kc]});
                    wt  = wts[idx];
                    acc = acc + act * wt;
                end
            end
        end
        return acc;
    endfunction

    function automatic logic [ACT_WIDTH-1:0] clamp(input logic signed [ACC_WIDTH-1:0] sum);
        if (sum < 0) begin
            return '0;
        end else if (sum > (2 ** ACT_WIDTH) - 1) begin
            return '1;
        end
        return sum[ACT_WIDTH-1:0];
    endfunction

    always_comb begin
        for (int oc = 0; oc < OUT_CHANNELS; oc++) begin
            next_beat.pixel.chan[oc] = clamp(channel_sum(window_i, weights_i, oc));
        end
        // Bottom-right pixel closes the frame
        next_beat.last = (read_coord_o.row == 3'(FRAME_HEIGHT - 1) &&
                          read_coord_o.col == 3'(FRAME_WIDTH - 1));
    end

    // Raster walk that wraps to the origin after the final pixel
    always_comb begin
        next_coord = read_coord_o;
        if (read_coord_o.col == 3'(FRAME_WIDTH - 1)) begin
            next_coord.col = '0;
            next_coord.row = read_coord_o.row + 3'd1;
        end else begin
            next_coord.col = read_coord_o.col + 3'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    // New beat enters the output register on frame start or after each handshake
    assign load_beat = (state == ST_IDLE && frame_full_i) ||
                       (state == ST_STREAM && m_ready_i && !m_beat_o.last);
    assign frame_done_o = (state == ST_DONE);

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state        <= ST_IDLE;
            read_coord_o <= '0;
            m_valid_o    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_full_i) begin
                        state     <= ST_STREAM;
                        m_valid_o <= 1'b1;
                    end
                end
                ST_STREAM: begin
                    if (m_ready_i && m_beat_o.last) begin
                        state     <= ST_DONE;
                        m_valid_o <= 1'b0;
                    end
                end
                // Single cycle to release the frame store
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
            if (load_beat) begin
                read_coord_o <= next_coord;
            end
        end
    end

    // Output payload held while stalled
    always_ff @(posedge clock_i) begin
        if (load_beat) begin
            m_beat_o <= next_beat;
        end
    end

endmodule : conv_engine

`default_nettype wire

/* design/conv_stream_top.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_stream_top
    import conv_pkg::*;
(
    input  wire logic                           clock_i,
    input  wire logic                           reset_i,

    // Input pixel stream
    input  wire logic                           s_valid_i,
    output logic                                s_ready_o,
    input  wire in_beat_t                       s_beat_i,

    // Output pixel stream
    output logic                                m_valid_o,
    input  wire logic                           m_ready_i,
    output out_beat_t                           m_beat_o,

    // Kernel weight write port
    input  wire logic                           weight_we_i,
    input  wire logic [WEIGHT_ADDR_WIDTH-1:0]   weight_addr_i,
    input  wire logic signed [WEIGHT_WIDTH-1:0] weight_data_i,

    output logic                                frame_error_o
);

    // Store to engine
    logic        frame_full;
    window_t     window;
    // Engine to store
    coord_t      read_coord;
    logic        frame_done;
    // Bank to engine
    weight_set_t weights;

    frame_store frame_store_inst (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .s_valid_i    (s_valid_i),
        .s_ready_o    (s_ready_o),
        .s_beat_i     (s_beat_i),
        .read_coord_i (read_coord),
        .frame_done_i (frame_done),
        .frame_full_o (frame_full),
        .window_o     (window),
        .frame_error_o(frame_error_o)
    );

    weight_bank weight_bank_inst (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .weight_we_i  (weight_we_i),
        .weight_addr_i(weight_addr_i),
        .weight_data_i(weight_data_i),
        .weights_o    (weights)
    );

    conv_engine conv_engine_inst (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .frame_full_i(frame_full),
        .window_i    (window),
        .read_coord_o(read_coord),
        .frame_done_o(frame_done),
        .weights_i   (weights),
        .m_valid_o   (m_valid_o),
        .m_ready_i   (m_ready_i),
        .m_beat_o    (m_beat_o)
    );

endmodule : conv_stream_top

`default_nettype wire

/* tb/conv_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_sva
    import conv_pkg::*;
(
    input wire logic      clock_i,
    input wire logic      reset_i,
    input wire logic      s_ready_i,
    input wire logic      m_valid_i,
    input wire logic      m_ready_i,
    input wire out_beat_t m_beat_i
);

    // Number of failed assertions, read by the testbench at the end
    int failure_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Stream protocol
    ////////////////////////////////////////////////////////////////////////////

    // Output beat held while the sink stalls
    m_stall_hold: assert property (
        @(posedge clock_i) disable iff (reset_i)
        m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_beat_i)
    ) else begin
        $error("Output beat or valid changed while stalled");
        failure_count++;
    end

    // Fill and stream phases never overlap
    phase_exclusive: assert property (
        @(posedge clock_i) disable iff (reset_i)
        !(s_ready_i && m_valid_i)
    ) else begin
        $error("Input ready and output valid high in the same cycle");
        failure_count++;
    end

    reset_quiet: assert property (
        @(posedge clock_i) reset_i |=> !m_valid_i
    ) else begin
        $error("Output valid high in the cycle after reset");
        failure_count++;
    end

endmodule : conv_sva

bind conv_stream_top conv_sva conv_sva_inst (
    .clock_i  (clock_i),
    .reset_i  (reset_i),
    .s_ready_i(s_ready_o),
    .m_valid_i(m_valid_o),
    .m_ready_i(m_ready_i),
    .m_beat_i (m_beat_o)
);

`default_nettype wire

/* tb/conv_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_tb
    import conv_pkg::*;
();

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    // Eight frames of at most ~64 input and ~256 output cycles, plus kernel loads
    localparam int MAX_CYCLES   = 6000;

    logic                           clock;
    logic                           reset;
    logic                           s_valid;
    logic                           s_ready;
    in_beat_t                       s_beat;
    logic                           m_valid;
    logic                           m_ready;
    out_beat_t                      m_beat;
    logic                           weight_we;
    logic [WEIGHT_ADDR_WIDTH-1:0]   weight_addr;
    logic signed [WEIGHT_WIDTH-1:0] weight_data;
    logic                           frame_error;

    // Stimulus and reference state
    logic [31:0] rng_state;
    in_pixel_t   frame    [PIXELS_PER_FRAME];
    byte         kernel   [WEIGHT_COUNT];
    out_pixel_t  expected [PIXELS_PER_FRAME];
    int          cycle_count;
    int          error_count;
    int          test_count;
    int          ready_percent;
    string       test_name;

    conv_stream_top dut (
        .clock_i      (clock),
        .reset_i      (reset),
        .s_valid_i    (s_valid),
        .s_ready_o    (s_ready),
        .s_beat_i     (s_beat),
        .m_valid_o    (m_valid),
        .m_ready_i    (m_ready),
        .m_beat_o     (m_beat),
        .weight_we_i  (weight_we),
        .weight_addr_i(weight_addr),
        .weight_data_i(weight_data),
        .frame_error_o(frame_error)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    // Watchdog on the cycle count
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int weight_index(input int oc, input int ic, input int kr, input int kc);
        return ((oc * IN_CHANNELS + ic) * KERNEL_SIZE + kr) * KERNEL_SIZE + kc;
    endfunction

    // Zero padding, sum over input channels and kernel taps, clamp to 0..255
    function automatic void compute_expected();
        int sum;
        int rr;
        int cc;
        for (int p = 0; p < PIXELS_PER_FRAME; p++) begin
            for (int oc = 0; oc < OUT_CHANNELS; oc++) begin
                sum = 0;
                for (int ic = 0; ic < IN_CHANNELS; ic++) begin
                    for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
                        for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                            rr = p / FRAME_WIDTH + kr - 1;
                            cc = p % FRAME_WIDTH + kc - 1;
                            if (rr >= 0 && rr < FRAME_HEIGHT && cc >= 0 && cc < FRAME_WIDTH) begin
                                sum += int'(frame[rr * FRAME_WIDTH + cc].chan[ic]) *
                                       int'(kernel[weight_index(oc, ic, kr, kc)]);
                            end
                        end
                    end
                end
                expected[p].chan[oc] = (sum < 0) ? 8'd0 : (sum > 255) ? 8'd255 : 8'(sum);
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Drivers, all on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    // Weights drawn from lo .. lo+span-1
    task automatic fill_kernel(input int lo, input int span);
        foreach (kernel[i]) begin
            kernel[i] = byte'(lo + int'((next_random() >> 8) % 32'(span)));
        end
    endtask

    task automatic fill_frame(input bit random, input logic [7:0] value);
        foreach (frame[i]) begin
            for (int c = 0; c < IN_CHANNELS; c++) begin
                frame[i].chan[c] = random ? (8'(next_random() >> 24) | value) : value;
            end
        end
    endtask

    task automatic load_kernel();
        for (int i = 0; i < WEIGHT_COUNT; i++) begin
            @(negedge clock);
            weight_we   = 1'b1;
            weight_addr = WEIGHT_ADDR_WIDTH'(i);
            weight_data = kernel[i];
        end
        // Write past the last weight that the bank drops
        @(negedge clock);
        weight_addr = '1;
        weight_data = 8'sd127;
        @(negedge clock);
        weight_we = 1'b0;
    endtask

    // Ready seen in the low phase means the beat moves at the next rising edge
    task automatic send_frame(input int last_at);
        int idx;
        idx = 0;
        while (idx < PIXELS_PER_FRAME) begin
            @(negedge clock);
            s_valid      = 1'b1;
            s_beat.pixel = frame[idx];
            s_beat.last  = (idx == last_at);
            if (s_ready) begin
                idx++;
            end
        end
        @(negedge clock);
        s_valid = 1'b0;
    endtask

    task automatic check_beat(input int idx);
        out_beat_t want;
        want.pixel = expected[idx];
        want.last  = (idx == PIXELS_PER_FRAME - 1);
        assert (m_beat == want) else begin
            $display("FAILED %s beat %0d: expected %h, actual %h", test_name, idx, want, m_beat);
            error_count++;
        end
    endtask

    task automatic receive_frame();
        int idx;
        idx = 0;
        while (idx < PIXELS_PER_FRAME) begin
            @(negedge clock);
            m_ready = ((next_random() >> 16) % 32'd100) < 32'(ready_percent);
            if (m_valid && m_ready) begin
                check_beat(idx);
                idx++;
            end
        end
        @(negedge clock);
        m_ready = 1'b0;
    endtask

    task automatic run_frame(input int last_at);
        compute_expected();
        send_frame(last_at);
        receive_frame();
    endtask

    task automatic finish_test(input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%-14s passed", test_name);
        end else begin
            $display("%-14s failed with %0d errors", test_name, error_count - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int errors_before;
        rng_state     = 32'h18a8_4690;
        error_count   = 0;
        test_count    = 0;
        ready_percent = 100;
        reset         = 1'b1;
        s_valid       = 1'b0;
        s_beat        = '0;
        m_ready       = 1'b0;
        weight_we     = 1'b0;
        weight_addr   = '0;
        weight_data   = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Centre tap passes each channel straight through
        test_name = "identity";
        errors_before = error_count;
        fill_kernel(0, 1);
        for (int c = 0; c < OUT_CHANNELS; c++) begin
            kernel[weight_index(c, c, 1, 1)] = 1;
        end
        load_kernel();
        fill_frame(1'b1, 8'h00);
        run_frame(PIXELS_PER_FRAME - 1);
        finish_test(errors_before);

        // Small v keeps 18v, 12v and 8v below the clamp
        test_name = "border_padding";
        errors_before = error_count;
        fill_kernel(1, 1);
        load_kernel();
        fill_frame(1'b0, 8'd5);
        run_frame(PIXELS_PER_FRAME - 1);
        finish_test(errors_before);

        test_name = "random_frame";
        errors_before = error_count;
        fill_kernel(-128, 256);
        load_kernel();
        fill_frame(1'b1, 8'h00);
        run_frame(PIXELS_PER_FRAME - 1);
        finish_test(errors_before);

        // Pixels of at least 16 push every sum past the clamp
        test_name = "saturation";
        errors_before = error_count;
        fill_kernel(-128, 1);
        load_kernel();
        fill_frame(1'b1, 8'h10);
        run_frame(PIXELS_PER_FRAME - 1);
        fill_kernel(127, 1);
        load_kernel();
        fill_frame(1'b1, 8'h10);
        run_frame(PIXELS_PER_FRAME - 1);
        finish_test(errors_before);

        test_name = "back_pressure";
        errors_before = error_count;
        fill_kernel(-8, 16);
        load_kernel();
        fill_frame(1'b1, 8'h00);
        ready_percent = 50;
        run_frame(PIXELS_PER_FRAME - 1);
        // Next frame right behind the stalled one
        ready_percent = 100;
        fill_frame(1'b1, 8'h00);
        run_frame(PIXELS_PER_FRAME - 1);
        finish_test(errors_before);

        // tlast on beat 10 of 64
        test_name = "framing_error";
        errors_before = error_count;
        assert (frame_error == 1'b0) else begin
            $display("FAILED %s before frame: expected 0, actual %b", test_name, frame_error);
            error_count++;
        end
        fill_frame(1'b1, 8'h00);
        run_frame(9);
        assert (frame_error == 1'b1) else begin
            $display("FAILED %s after frame: expected 1, actual %b", test_name, frame_error);
            error_count++;
        end
        finish_test(errors_before);

        $display("%0d tests run, %0d errors, %0d protocol assertion failures",
                 test_count, error_count, dut.conv_sva_inst.failure_count);
        if (error_count == 0 && dut.conv_sva_inst.failure_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : conv_tb

`default_nettype wire

/* sim.f */
design/conv_pkg.sv
design/frame_store.sv
design/weight_bank.sv
design/conv_engine.sv
design/conv_stream_top.sv
tb/conv_sva.sv
tb/conv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the convolution testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_tb -f sim.f -o conv_tb_sim

# An aborted run also ends the script through pipefail
./obj_dir/conv_tb_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
